// ==== test/decoder_stim.txt ====
// insn imm flags(bit0 imm, bit1 hazard) e_a e_b m_a1
// ctl = {alu_op[31:24], r_op[23:20], r_a1[19:12], m1_op[11:8], m2_op[7:4], write_flags[3:0]}
020110C0 00000000 0 10000011 10000022 00000000 0D10311F
1C042980 00000000 0 10000044 10000055 00000000 0110611F
0A070200 00000000 0 10000077 00000000 00000000 0B10811F
28090280 00000000 0 10000099 00000001 00000000 0110A11F
2A020080 00000000 0 10000022 00000001 00000000 0210211F
1E010150 00001234 1 10000011 00001234 00000000 0210511F
3A030300 00000000 0 00000000 00000000 10000033 0010C210
3A040360 00008000 1 00000000 00000000 00008000 0010D210
3C063800 00000000 0 00000000 10000077 10000066 00000150
2C084800 00000000 0 10000088 10000099 00000000 0200011F
2E0A5800 00000000 0 100000AA 100000BB 00000000 0100011F
300C6800 00000000 0 100000CC 100000DD 00000000 0C00011F
320E0000 00000000 0 100000EE 00000000 00000000 0011F110
38000000 00000000 0 100001ED 00000000 00000000 0011F110
0C0110C0 00000000 2 10000011 10000022 00000000 0E10311F
04021900 00000000 0 10000022 10000033 00000000 1010411F
080531C0 00000000 2 10000055 10000066 00000000 0F10711F
06042980 00000000 0 10000044 10000055 00000000 0C10611F
0E074240 00000000 0 10000077 10000088 00000000 1110911F

// ==== all.f ====
+incdir+logic
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/pipe_ifs.sv
logic/reg_hazard_checker.sv
logic/insn_fetch_decode.sv
logic/decode_hold_buffer.sv
logic/operand_issue.sv
logic/insn_decoder_top.sv
test/insn_decoder_sva.sv
test/insn_decoder_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module insn_decoder_tb -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -qx "test passed"; then
    exit 0
fi
exit 1

// ==== test/insn_decoder_tb.sv ====
`timescale 1ns/100ps
`include "isa_config.svh"

module insn_decoder_tb
    import pipe_pkg::*;
();

    localparam int NUM_REC  = 19;       // records in the stim file
    localparam int REC_W    = 7;        // words per record
    localparam int TIMEOUT  = NUM_REC * 12 + 10;

    logic               clk;
    logic               rst;
    logic [`DATA_W-1:0] word;
    logic [`DATA_W-1:0] r1, r2;
    logic [`REG_AW-1:0] ex_r1_a, ex_r2_a, mem_r1_a, mem_r2_a, reg_r1_a, reg_r2_a;
    logic [3:0]         ex_r_op, mem_r_op;
    logic               ex_proceed, mem_proceed;
    logic [1:0]         reg_write;
    logic [`DATA_W-1:0] e_a, e_b, m_a1, m_a2;
    logic [7:0]         e_alu_op;
    logic [3:0]         e_cond, e_write_flags;
    logic               e_is_cond;
    logic [3:0]         m_r1_op, m_r2_op, r_op;
    logic [`REG_AW-1:0] r_a1, r_a2, r_r1_addr, r_r2_addr;
    logic [1:0]         r_read;
    logic               d_pass, d_pcincr;

    logic [31:0] stim_mem [0:NUM_REC*REC_W-1];
    logic [31:0] lfsr = 32'hdac4;
    int          rec_idx = 0;     // next record expected to issue
    int          val_errs = 0;
    int          other_errs = 0;
    int          haz_cnt = 0;     // cycles left in the hazard window
    int          haz_rec = -1;    // record the window blocks
    logic        br_mark = 1'b0;  // br or ret taken at the last edge
    logic        br_watch = 1'b0;
    int          br_low = 0;

    insn_decoder_top insn_decoder_top_inst (.*);

    function automatic logic [31:0] reg_file_value(input logic [`REG_AW-1:0] addr);
        return 32'h1000_0000 + 32'(addr) * 32'h11;
    endfunction

    // register file model, same cycle read, all ones on a port not requested
    assign r1 = r_read[0] ? reg_file_value(r_r1_addr) : '1;
    assign r2 = r_read[1] ? reg_file_value(r_r2_addr) : '1;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic lfsr_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];   // taps 32 22 2 1
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (act !== exp) begin
            val_errs++;
            $display("Error %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    initial begin
        int          wi;
        int          n;
        logic        take;
        logic [31:0] words [$];
        int          tags [$];    // record index, -1 for an immediate
        rst = 1'b1;
        word = '0;
        ex_r1_a = '0;
        ex_r2_a = '0;
        mem_r1_a = '0;
        mem_r2_a = '0;
        reg_r1_a = '0;
        reg_r2_a = '0;
        ex_r_op = WB_NONE;
        mem_r_op = WB_NONE;
        ex_proceed = 1'b1;
        mem_proceed = 1'b1;
        reg_write = 2'b00;
        $readmemh("test/decoder_stim.txt", stim_mem);
        for (int r = 0; r < NUM_REC; r++) begin
            words.push_back(stim_mem[r*REC_W]);
            tags.push_back(r);
            if (stim_mem[r*REC_W+2][0]) begin
                words.push_back(stim_mem[r*REC_W+1]);
                tags.push_back(-1);
            end
        end
        repeat (10) @(posedge clk);
        #2 rst = 1'b0;
        wi = 0;
        word = words[0];
        while (rec_idx < NUM_REC) begin
            @(negedge clk);
            take = d_pcincr;                   // word is sampled at the next edge
            @(posedge clk);
            #2;
            br_mark = 1'b0;
            if (haz_cnt > 0) haz_cnt--;
            if (haz_cnt == 0) ex_r_op = WB_NONE;
            if (take && wi < words.size()) begin
                if (tags[wi] >= 0) begin
                    if (words[wi][31:25] == 7'd25 || words[wi][31:25] == 7'd28) begin
                        br_mark = 1'b1;        // br or ret accepted
                    end
                    if (stim_mem[tags[wi]*REC_W+2][1]) begin
                        n = int'(lfsr_bit());
                        n = 2 * n + int'(lfsr_bit()) + 1;
                        haz_cnt = 2 + n;       // two cycles to reach the buffer
                        haz_rec = tags[wi];
                        ex_r1_a = words[wi][20:16];
                        ex_r_op = WB_A1;
                    end
                end
                wi++;
                word = (wi < words.size()) ? words[wi] : '0;
            end
        end
    end

    always @(negedge clk) begin
        if (!rst && br_mark) begin
            br_watch = 1'b1;
            br_low   = 0;
        end
        if (!rst && br_watch) begin
            if (!d_pcincr) begin
                br_low++;
            end else begin
                check_value("branch fetch stop", `BRANCH_DELAY + 1, br_low);  // push cycle too
                br_watch = 1'b0;
            end
        end
        if (!rst && d_pass && rec_idx < NUM_REC) begin
            int                 b;
            logic [31:0]        x;
            logic [`REG_AW-1:0] rb;
            b  = rec_idx * REC_W;
            x  = stim_mem[b+6];                // packed control fields
            rb = stim_mem[b][15:11];           // store data register
            if (rec_idx == haz_rec && haz_cnt != 0) begin
                other_errs++;
                $display("record %0d issued while its hazard window was open", rec_idx);
            end
            check_value("e_a", stim_mem[b+3], e_a);
            check_value("e_b", stim_mem[b+4], e_b);
            check_value("m_a1", stim_mem[b+5], m_a1);
            check_value("m_a2", (x[7:4] == MEM_WRITE) ? reg_file_value(rb) : 32'h0, m_a2);
            check_value("e_alu_op", {24'h0, x[31:24]}, {24'h0, e_alu_op});
            check_value("r_op", {28'h0, x[23:20]}, {28'h0, r_op});
            check_value("r_a1", {27'h0, x[16:12]}, {27'h0, r_a1});
            check_value("r_a2", 32'h0, {27'h0, r_a2});      // no kept opcode writes a2
            check_value("m_r1_op", {28'h0, x[11:8]}, {28'h0, m_r1_op});
            check_value("m_r2_op", {28'h0, x[7:4]}, {28'h0, m_r2_op});
            check_value("e_write_flags", {28'h0, x[3:0]}, {28'h0, e_write_flags});
            check_value("e_cond", {28'h0, stim_mem[b][24:21]}, {28'h0, e_cond});
            // every opcode but nop runs under its cond field
            check_value("e_is_cond", {31'h0, stim_mem[b][31:25] != 7'd0},
                        {31'h0, e_is_cond});
            rec_idx++;
        end
    end

    initial begin
        wait (rec_idx == NUM_REC);
        repeat (2) @(posedge clk);
        $display("records %0d, value errors %0d, other errors %0d",
                 rec_idx, val_errs, other_errs);
        if (val_errs == 0 && other_errs == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        repeat (TIMEOUT) @(posedge clk);
        $display("watchdog expired with %0d of %0d records issued", rec_idx, NUM_REC);
        $display("test failed");
        $finish;
    end

endmodule

// ==== test/insn_decoder_sva.sv ====
`timescale 1ns/100ps
`include "isa_config.svh"

module insn_decoder_sva (
    input logic       clk,
    input logic       rst,
    input logic       d_pass,
    input logic       d_pcincr,
    input logic [1:0] r_read,
    input logic       push,
    input logic       branch     // producer holds br or ret
);

    logic       br_push;
    logic [1:0] held;    // entries pushed and not yet passed

    assign br_push = push && branch;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            held <= '0;
        end else begin
            held <= held + 2'(push) - 2'(d_pass);
        end
    end

    // back to back passes need a fresh push in between
    a_single_pass: assert property (@(posedge clk) disable iff (rst)
        (d_pass && !$past(push)) |=> !d_pass) else $error("entry issued twice");

    a_delay_start: assert property (@(posedge clk) disable iff (rst)
        $past(br_push, 1) |-> !d_pcincr) else $error("fetch resumed early");

    a_delay_end: assert property (@(posedge clk) disable iff (rst)
        $past(br_push, `BRANCH_DELAY) |-> !d_pcincr) else $error("branch delay too short");

    a_delay_resume: assert property (@(posedge clk) disable iff (rst)
        $past(br_push, `BRANCH_DELAY + 1) |-> d_pcincr) else $error("branch delay too long");

    a_idle_read: assert property (@(posedge clk) disable iff (rst)
        held == 2'd0 |-> r_read == 2'b00) else $error("read request with empty buffer");

endmodule

bind insn_decoder_top insn_decoder_sva sva_inst (
    .clk,
    .rst,
    .d_pass,
    .d_pcincr,
    .r_read,
    .push   (dec_bus.push),
    .branch (fetch_inst.branch_q)
);

// ==== logic/insn_decoder_top.sv ====
`timescale 1ns/100ps
`include "isa_config.svh"

module insn_decoder_top (
    input  logic               clk,
    input  logic               rst,
    input  logic [`DATA_W-1:0] word,       // fetch port
    input  logic [`DATA_W-1:0] r1,         // register file read data
    input  logic [`DATA_W-1:0] r2,
    input  logic [`REG_AW-1:0] ex_r1_a,
    input  logic [`REG_AW-1:0] ex_r2_a,
    input  logic [`REG_AW-1:0] mem_r1_a,
    input  logic [`REG_AW-1:0] mem_r2_a,
    input  logic [`REG_AW-1:0] reg_r1_a,
    input  logic [`REG_AW-1:0] reg_r2_a,
    input  logic [3:0]         ex_r_op,
    input  logic [3:0]         mem_r_op,
    input  logic               ex_proceed,
    input  logic               mem_proceed,
    input  logic [1:0]         reg_write,
    output logic [`DATA_W-1:0] e_a,
    output logic [`DATA_W-1:0] e_b,
    output logic [`DATA_W-1:0] m_a1,
    output logic [`DATA_W-1:0] m_a2,
    output logic [7:0]         e_alu_op,
    output logic [3:0]         e_cond,
    output logic [3:0]         e_write_flags,
    output logic               e_is_cond,
    output logic [3:0]         m_r1_op,
    output logic [3:0]         m_r2_op,
    output logic [3:0]         r_op,
    output logic [`REG_AW-1:0] r_a1,
    output logic [`REG_AW-1:0] r_a2,
    output logic [`REG_AW-1:0] r_r1_addr,
    output logic [`REG_AW-1:0] r_r2_addr,
    output logic [1:0]         r_read,
    output logic               d_pass,     // one issue per pulse
    output logic               d_pcincr    // fetch advance
);

    decode_if dec_bus ();   // producer to buffer
    issue_if  iss_bus ();   // buffer to consumer

    insn_fetch_decode fetch_inst (
        .clk,
        .rst,
        .word,
        .d_pcincr,
        .dec      (dec_bus.producer)
    );

    decode_hold_buffer hold_inst (
        .clk,
        .rst,
        .dec (dec_bus.buffer),
        .iss (iss_bus.buffer)
    );

    operand_issue issue_inst (
        .iss (iss_bus.consumer),
        .*
    );

endmodule

// ==== logic/operand_issue.sv ====
`timescale 1ns/100ps
`include "isa_config.svh"

module operand_issue
    import pipe_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    issue_if.consumer          iss,
    input  logic [`DATA_W-1:0] r1,
    input  logic [`DATA_W-1:0] r2,
    input  logic [`REG_AW-1:0] ex_r1_a, ex_r2_a,
    input  logic [`REG_AW-1:0] mem_r1_a, mem_r2_a,
    input  logic [`REG_AW-1:0] reg_r1_a, reg_r2_a,
    input  logic [3:0]         ex_r_op, mem_r_op,
    input  logic               ex_proceed, mem_proceed,
    input  logic [1:0]         reg_write,
    output logic [`DATA_W-1:0] e_a, e_b, m_a1, m_a2,
    output logic [7:0]         e_alu_op,
    output logic [3:0]         e_cond, e_write_flags,
    output logic               e_is_cond,
    output logic [3:0]         m_r1_op, m_r2_op, r_op,
    output logic [`REG_AW-1:0] r_a1, r_a2, r_r1_addr, r_r2_addr,
    output logic [1:0]         r_read,
    output logic               d_pass
);

    operand_src_t       src;
    logic               hazard;
    logic [`DATA_W-1:0] a_val;    // operand a after imm select
    logic [`DATA_W-1:0] b_val;

    assign src = iss.src;

    reg_hazard_checker hazard_inst (
        .rd1_addr (src.r1_addr),
        .rd2_addr (src.r2_addr),
        .rd_mask  (src.rd_mask),
        .ex_r1_a,
        .ex_r2_a,
        .ex_r_op,
        .ex_proceed,
        .mem_r1_a,
        .mem_r2_a,
        .mem_r_op,
        .mem_proceed,
        .reg_r1_a,
        .reg_r2_a,
        .reg_write,
        .hazard
    );

    assign iss.pop   = iss.valid && !hazard;             // issue when operands are clean
    assign r_read    = iss.valid ? src.rd_mask : 2'b00;  // register file read request
    assign r_r1_addr = iss.valid ? src.r1_addr : '0;
    assign r_r2_addr = iss.valid ? src.r2_addr : '0;

    // the immediate takes the slot of the register it replaces
    assign a_val = (src.imm_valid && src.imm_to_a) ? src.imm : (src.rd_mask[0] ? r1 : '0);
    assign b_val = (src.imm_valid && !src.imm_to_a) ? src.imm : (src.rd_mask[1] ? r2 : '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            d_pass        <= 1'b0;
            e_a           <= '0;
            e_b           <= '0;
            m_a1          <= '0;
            m_a2          <= '0;
            e_alu_op      <= '0;
            e_cond        <= '0;
            e_write_flags <= '0;
            e_is_cond     <= 1'b0;
            m_r1_op       <= MEM_IDLE;
            m_r2_op       <= MEM_IDLE;
            r_op          <= WB_NONE;
            r_a1          <= '0;
            r_a2          <= '0;
        end else begin
            d_pass <= iss.pop;                           // one pulse per entry
            if (iss.pop) begin
                e_a           <= src.r1_to_m ? '0 : a_val;
                e_b           <= b_val;
                m_a1          <= src.r1_to_m ? a_val : '0;  // memory address
                m_a2          <= src.r1_to_m ? b_val : '0;  // store data
                e_alu_op      <= iss.ctrl.alu_op;
                e_cond        <= iss.ctrl.cond;
                e_write_flags <= iss.ctrl.write_flags;
                e_is_cond     <= iss.ctrl.is_cond;
                m_r1_op       <= iss.ctrl.m1_op;
                m_r2_op       <= iss.ctrl.m2_op;
                r_op          <= iss.ctrl.wb_op;
                r_a1          <= iss.ctrl.wb_a1;
                r_a2          <= iss.ctrl.wb_a2;
            end
        end
    end

endmodule

// ==== logic/decode_hold_buffer.sv ====
`timescale 1ns/100ps
`include "isa_config.svh"

module decode_hold_buffer
    import pipe_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    decode_if.buffer dec,
    issue_if.buffer  iss
);

    dec_ctrl_t    ctrl_q;    // held entry
    operand_src_t src_q;
    logic         valid_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (dec.push) begin
            valid_q <= 1'b1;     // push wins over a same cycle pop
        end else if (iss.pop) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (dec.push) begin
            ctrl_q <= dec.ctrl;
            src_q  <= dec.src;
        end
    end

    // a leaving entry frees the slot in the same cycle
    assign dec.full  = valid_q && !iss.pop;
    assign iss.valid = valid_q;
    assign iss.ctrl  = ctrl_q;
    assign iss.src   = src_q;

endmodule

// ==== logic/insn_fetch_decode.sv ====
`timescale 1ns/100ps
`include "isa_config.svh"

module insn_fetch_decode
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic [`DATA_W-1:0] word,
    output logic               d_pcincr,
    decode_if.producer         dec
);

    typedef enum logic [1:0] {S_FETCH, S_IMM, S_PUSH, S_DELAY} state_t;
    localparam int CNT_W = $clog2(`BRANCH_DELAY + 1);

    state_t           state;
    logic [CNT_W-1:0] delay_cnt;     // branch delay down counter
    logic             branch_q;      // held entry is br or ret
    dec_ctrl_t        ctrl_q;
    operand_src_t     src_q;
    fetch_word_u      fw;
    insn_fields_t     f;
    dec_ctrl_t        dec_ctrl;
    operand_src_t     dec_src;
    logic             dec_need_imm;
    logic             dec_branch;
    logic             take_insn;

    assign fw = word;
    assign f  = fw.insn;

    assign dec_branch = (f.opcode == OP_BR) || (f.opcode == OP_RET);

    always_comb begin
        dec_ctrl             = '0;
        dec_ctrl.cond        = f.cond;
        dec_ctrl.is_cond     = 1'b1;
        dec_ctrl.write_flags = 4'hF;      // all flags
        dec_ctrl.wb_op       = WB_A1;     // rc to a1
        dec_ctrl.wb_a1       = f.rc;
        dec_ctrl.m1_op       = MEM_PASS;
        dec_ctrl.m2_op       = MEM_PASS;
        dec_src              = '0;
        dec_src.r1_addr      = f.ra;
        dec_src.r2_addr      = f.rb;
        dec_src.rd_mask      = 2'b11;     // read both
        dec_need_imm         = 1'b0;
        case (f.opcode)
            OP_OR:   dec_ctrl.alu_op = ALU_OR;
            OP_NOR:  dec_ctrl.alu_op = ALU_NOR;
            OP_AND:  dec_ctrl.alu_op = ALU_AND;
            OP_NAND: dec_ctrl.alu_op = ALU_NAND;
            OP_XOR:  dec_ctrl.alu_op = ALU_XOR;
            OP_XNOR: dec_ctrl.alu_op = ALU_XNOR;
            OP_ADD:  dec_ctrl.alu_op = ALU_ADD;
            OP_SUB:  dec_ctrl.alu_op = ALU_SUB;
            OP_INV: begin
                dec_ctrl.alu_op = ALU_NOT;
                dec_src.rd_mask = 2'b01;  // ra only
            end
            OP_INC, OP_DEC: begin
                dec_ctrl.alu_op   = (f.opcode == OP_INC) ? ALU_ADD : ALU_SUB;
                dec_src.rd_mask   = 2'b01;
                dec_src.imm_valid = 1'b1; // constant one on b
                dec_src.imm       = `DATA_W'(1);
            end
            OP_CMP, OP_CMN, OP_TST: begin
                dec_ctrl.wb_op = WB_NONE; // flags only
                case (f.opcode)
                    OP_CMP:  dec_ctrl.alu_op = ALU_SUB;
                    OP_CMN:  dec_ctrl.alu_op = ALU_ADD;
                    default: dec_ctrl.alu_op = ALU_AND;
                endcase
            end
            OP_BR, OP_RET: begin
                dec_ctrl.alu_op      = ALU_NOP;
                dec_ctrl.write_flags = 4'h0;
                dec_ctrl.wb_a1       = `REG_AW'(`PC_REG);  // target into pc
                dec_src.rd_mask      = 2'b01;
                if (f.opcode == OP_RET) begin
                    dec_src.r1_addr = `REG_AW'(`LR_REG);   // return address
                end
            end
            OP_LDR: begin
                dec_ctrl.write_flags = 4'h0;
                dec_ctrl.m1_op       = MEM_READ;           // load rc from m_a1
                dec_src.rd_mask      = 2'b01;
                dec_src.r1_to_m      = 1'b1;
            end
            OP_STR: begin
                dec_ctrl.write_flags = 4'h0;
                dec_ctrl.wb_op       = WB_NONE;
                dec_ctrl.m2_op       = MEM_WRITE;          // rb stored at ra
                dec_src.r1_to_m      = 1'b1;
            end
            default: begin                                 // nop and unused codes
                dec_ctrl        = '0;
                dec_src.rd_mask = 2'b00;
            end
        endcase
        if (!dec_src.imm_valid) begin
            if (f.imm_sel == 2'b01 && dec_src.rd_mask == 2'b11 && !dec_src.r1_to_m) begin
                dec_need_imm       = 1'b1;                 // imm replaces rb
                dec_src.rd_mask[1] = 1'b0;
            end else if (f.imm_sel == 2'b10 && dec_src.rd_mask[0] && f.opcode != OP_RET) begin
                dec_need_imm       = 1'b1;                 // imm replaces ra
                dec_src.imm_to_a   = 1'b1;
                dec_src.rd_mask[0] = 1'b0;
            end
        end
        dec_src.imm_valid = dec_src.imm_valid | dec_need_imm;
    end

    always_comb begin
        case (state)
            S_FETCH, S_IMM: d_pcincr = 1'b1;
            S_PUSH:         d_pcincr = !dec.full && !branch_q;  // next word as entry leaves
            default:        d_pcincr = 1'b0;                    // branch delay
        endcase
    end

    assign take_insn = d_pcincr && (state != S_IMM);   // word is an instruction
    assign dec.push  = (state == S_PUSH) && !dec.full;
    assign dec.ctrl  = ctrl_q;
    assign dec.src   = src_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= S_FETCH;
            delay_cnt <= '0;
            branch_q  <= 1'b0;
        end else if (take_insn) begin
            state    <= dec_need_imm ? S_IMM : S_PUSH;
            branch_q <= dec_branch;
        end else begin
            case (state)
                S_IMM: state <= S_PUSH;
                S_PUSH: begin
                    if (dec.push) begin                    // only a branch gets here
                        state     <= S_DELAY;
                        delay_cnt <= CNT_W'(`BRANCH_DELAY - 1);
                    end
                end
                S_DELAY: begin
                    if (delay_cnt == '0) begin
                        state <= S_FETCH;
                    end else begin
                        delay_cnt <= delay_cnt - 1'b1;
                    end
                end
                default: state <= S_FETCH;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take_insn) begin
            ctrl_q <= dec_ctrl;
            src_q  <= dec_src;
        end else if (state == S_IMM) begin
            src_q.imm <= fw.data;                          // immediate word
        end
    end

endmodule

// ==== logic/reg_hazard_checker.sv ====
`timescale 1ns/100ps
`include "isa_config.svh"

module reg_hazard_checker (
    input  logic [`REG_AW-1:0] rd1_addr,
    input  logic [`REG_AW-1:0] rd2_addr,
    input  logic [1:0]         rd_mask,
    input  logic [`REG_AW-1:0] ex_r1_a, ex_r2_a,
    input  logic [3:0]         ex_r_op,
    input  logic               ex_proceed,
    input  logic [`REG_AW-1:0] mem_r1_a, mem_r2_a,
    input  logic [3:0]         mem_r_op,
    input  logic               mem_proceed,
    input  logic [`REG_AW-1:0] reg_r1_a, reg_r2_a,
    input  logic [1:0]         reg_write,
    output logic               hazard
);

    logic [1:0] ex_dest;    // {writes a2, writes a1}
    logic [1:0] mem_dest;
    logic       ex_hit, mem_hit, reg_hit;

    function automatic logic [1:0] wb_dest(input logic [3:0] op);
        case (op)
            4'd1, 4'd2, 4'd3: return 2'b01;   // a1 only
            4'd4, 4'd5, 4'd6: return 2'b10;   // a2 only
            4'd7, 4'd8:       return 2'b11;   // both
            default:          return 2'b00;
        endcase
    endfunction

    // one write port against both reads, straight and crossed
    function automatic logic addr_hit(input logic w, input logic [`REG_AW-1:0] a);
        return w && ((rd_mask[0] && a == rd1_addr) || (rd_mask[1] && a == rd2_addr));
    endfunction

    always_comb begin
        ex_dest  = wb_dest(ex_r_op);
        mem_dest = wb_dest(mem_r_op);
        ex_hit   = addr_hit(ex_dest[0], ex_r1_a) || addr_hit(ex_dest[1], ex_r2_a);
        mem_hit  = addr_hit(mem_dest[0], mem_r1_a) || addr_hit(mem_dest[1], mem_r2_a);
        reg_hit  = addr_hit(reg_write[0], reg_r1_a) || addr_hit(reg_write[1], reg_r2_a);
        hazard   = (ex_hit && ex_proceed) || (mem_hit && mem_proceed) || reg_hit;
    end

endmodule

// ==== logic/pipe_ifs.sv ====
`timescale 1ns/100ps
`include "isa_config.svh"

interface decode_if import pipe_pkg::*; ();
    logic         push;   // one cycle strobe
    dec_ctrl_t    ctrl;
    operand_src_t src;
    logic         full;   // buffer cannot take a push

    modport producer (
        output push, ctrl, src,
        input  full
    );

    modport buffer (
        input  push, ctrl, src,
        output full
    );
endinterface

interface issue_if import pipe_pkg::*; ();
    logic         valid;
    dec_ctrl_t    ctrl;
    operand_src_t src;
    logic         pop;    // entry issues this cycle

    modport buffer (
        output valid, ctrl, src,
        input  pop
    );

    modport consumer (
        input  valid, ctrl, src,
        output pop
    );
endinterface

// ==== logic/pipe_pkg.sv ====
`include "isa_config.svh"

package pipe_pkg;

    // 1..3 write a1, 4..6 write a2, 7..8 write both
    typedef enum logic [3:0] {
        WB_NONE = 4'd0,
        WB_A1   = 4'd1,
        WB_A2   = 4'd4,
        WB_BOTH = 4'd7
    } wb_op_t;

    typedef enum logic [3:0] {
        MEM_IDLE  = 4'd0,   // clean nop
        MEM_PASS  = 4'd1,   // passthrough
        MEM_READ  = 4'd2,
        MEM_WRITE = 4'd5
    } mem_op_t;

    typedef struct packed {
        logic [7:0]         alu_op;
        logic [3:0]         cond;
        logic [3:0]         write_flags;
        logic               is_cond;
        wb_op_t             wb_op;
        logic [`REG_AW-1:0] wb_a1;
        logic [`REG_AW-1:0] wb_a2;
        mem_op_t            m1_op;
        mem_op_t            m2_op;
    } dec_ctrl_t;

    typedef struct packed {
        logic [`REG_AW-1:0] r1_addr;
        logic [`REG_AW-1:0] r2_addr;
        logic [1:0]         rd_mask;     // bit0 read r1, bit1 read r2
        logic               r1_to_m;     // read 1 lands in m_a1 not e_a
        logic               imm_valid;
        logic               imm_to_a;    // imm takes the a slot, else b
        logic [`DATA_W-1:0] imm;
    } operand_src_t;

endpackage

// ==== logic/isa_pkg.sv ====
`include "isa_config.svh"

package isa_pkg;

    typedef enum logic [6:0] {
        OP_NOP  = 7'd0,
        OP_OR   = 7'd1,
        OP_NOR  = 7'd2,
        OP_AND  = 7'd3,
        OP_NAND = 7'd4,
        OP_INV  = 7'd5,
        OP_XOR  = 7'd6,
        OP_XNOR = 7'd7,
        OP_ADD  = 7'd14,
        OP_SUB  = 7'd15,
        OP_INC  = 7'd20,   // b forced to one
        OP_DEC  = 7'd21,   // b forced to one
        OP_CMP  = 7'd22,
        OP_CMN  = 7'd23,
        OP_TST  = 7'd24,
        OP_BR   = 7'd25,
        OP_RET  = 7'd28,
        OP_LDR  = 7'd29,
        OP_STR  = 7'd30
    } opcode_t;

    typedef enum logic [7:0] {
        ALU_NOP  = 8'h00,
        ALU_ADD  = 8'h01,
        ALU_SUB  = 8'h02,
        ALU_NOT  = 8'h0B,
        ALU_AND  = 8'h0C,
        ALU_OR   = 8'h0D,
        ALU_XOR  = 8'h0E,
        ALU_NAND = 8'h0F,
        ALU_NOR  = 8'h10,
        ALU_XNOR = 8'h11
    } alu_op_t;

    typedef struct packed {
        opcode_t            opcode;    // [31:25]
        logic [3:0]         cond;      // [24:21]
        logic [`REG_AW-1:0] ra;        // [20:16] first source
        logic [`REG_AW-1:0] rb;        // [15:11] second source
        logic [`REG_AW-1:0] rc;        // [10:6] destination
        logic [1:0]         imm_sel;   // 01 imm to b, 10 imm to a, 11 none
        logic [3:0]         spare;
    } insn_fields_t;

    // one fetched word, seen as an instruction or as an immediate
    typedef union packed {
        insn_fields_t       insn;
        logic [`DATA_W-1:0] data;
    } fetch_word_u;

endpackage

// ==== logic/isa_config.svh ====
`ifndef ISA_CONFIG_SVH
`define ISA_CONFIG_SVH

`define DATA_W       32   // data and instruction word
`define REG_AW       5    // register address width
`define PC_REG       31   // program counter
`define LR_REG       29   // link register
`define BRANCH_DELAY 3    // fetch stop cycles after br or ret

`endif
